/* all.f */
hdl/spi_cmd_pkg.sv
hdl/spi_frame_port.sv
hdl/cmd_decode.sv
hdl/reg_execute.sv
hdl/resp_result.sv
hdl/spi_cmd_top.sv
verification/clk_gen.sv
verification/spi_cmd_checker.sv
verification/tb_spi_cmd.sv

/* hdl/cmd_decode.sv */
module cmd_decode (
    input  logic                                   clk,
    input  logic                                   nrst,
    input  logic [spi_cmd_pkg::FRAME_BITS-1:0]     frame_data,
    input  logic [spi_cmd_pkg::LEN_BITS-1:0]       frame_len,
    input  logic                                   frame_valid,
    output logic                                   cmd_valid,
    output logic [7:0]                             cmd_op,
    output logic [spi_cmd_pkg::REG_ADDR_BITS-1:0]  cmd_addr,
    output logic [spi_cmd_pkg::DATA_BITS-1:0]      cmd_data,
    output logic [7:0]                             cmd_status
);
    import spi_cmd_pkg::*;

    localparam int SHAMT_BITS = LEN_BITS + 3;

    logic [SHAMT_BITS-1:0]  shamt;
    logic [FRAME_BITS-1:0]  head;
    logic [7:0]             op_byte;
    logic [7:0]             addr_byte;
    logic [DATA_BITS-1:0]   data_field;
    logic                   op_known;
    logic                   has_addr;
    logic [LEN_BITS-1:0]    exp_len;
    logic [7:0]             status;

    // align the first received byte to the top, empty frame leaves all zero
    assign shamt = (frame_len >= LEN_BITS'(FRAME_BYTES)) ? '0
                 : SHAMT_BITS'(FRAME_BITS) - {frame_len, 3'b000};
    assign head  = frame_data << shamt;

    assign op_byte    = head[FRAME_BITS-1 -: 8];
    assign addr_byte  = head[FRAME_BITS-9 -: 8];
    assign data_field = head[FRAME_BITS-17 -: DATA_BITS];   // big-endian

    always_comb begin
        op_known = 1'b1;
        has_addr = 1'b1;
        exp_len  = '0;
        case (op_byte)
            OP_WRITE:  exp_len = LEN_WRITE;
            OP_READ:   exp_len = LEN_READ;
            OP_ADD:    exp_len = LEN_ADD;
            OP_STATUS: begin
                exp_len  = LEN_STATUS;
                has_addr = 1'b0;
            end
            default: begin
                op_known = 1'b0;
                has_addr = 1'b0;
            end
        endcase

        // priority: opcode, then length, then address
        if (!op_known) begin
            status = ST_BAD_OP;
        end else if (frame_len != exp_len) begin
            status = ST_BAD_LEN;
        end else if (has_addr && addr_byte >= 8'(REG_COUNT)) begin
            status = ST_BAD_ADDR;
        end else begin
            status = ST_OK;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= frame_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid) begin
            cmd_op     <= op_byte;
            cmd_status <= status;
            // address and data only carried for good commands
            cmd_addr   <= (status == ST_OK && has_addr) ? addr_byte[REG_ADDR_BITS-1:0] : '0;
            cmd_data   <= (status == ST_OK) ? data_field : '0;
        end
    end

endmodule

/* hdl/reg_execute.sv */
module reg_execute (
    input  logic                                   clk,
    input  logic                                   nrst,
    input  logic                                   cmd_valid,
    input  logic [7:0]                             cmd_op,
    input  logic [spi_cmd_pkg::REG_ADDR_BITS-1:0]  cmd_addr,
    input  logic [spi_cmd_pkg::DATA_BITS-1:0]      cmd_data,
    input  logic [7:0]                             cmd_status,
    output logic                                   res_valid,
    output logic [7:0]                             res_status,
    output logic [spi_cmd_pkg::REG_ADDR_BITS-1:0]  res_addr,
    output logic [spi_cmd_pkg::DATA_BITS-1:0]      res_data
);
    import spi_cmd_pkg::*;

    logic [DATA_BITS-1:0]  regs [REG_COUNT];
    logic [CNT_BITS-1:0]   cmd_cnt;     // all whole-byte commands
    logic [CNT_BITS-1:0]   err_cnt;     // commands that failed decode
    logic                  cmd_ok;
    logic                  do_store;
    logic [DATA_BITS-1:0]  cur_val;
    logic [DATA_BITS-1:0]  new_val;

    assign cmd_ok  = (cmd_status == ST_OK);
    assign cur_val = regs[cmd_addr];

    ////////////////////////////////////////////////////////////
    // command result
    ////////////////////////////////////////////////////////////
    always_comb begin
        new_val  = '0;
        do_store = 1'b0;
        case (cmd_op)
            OP_WRITE: begin
                new_val  = cmd_data;
                do_store = cmd_ok;
            end
            OP_ADD: begin
                new_val  = cur_val + cmd_data;     // wraps at 2^32
                do_store = cmd_ok;
            end
            OP_READ:   new_val = cur_val;
            OP_STATUS: new_val = {cmd_cnt, err_cnt};  // counts before this command
            default:   new_val = '0;
        endcase

        if (!cmd_ok) begin
            new_val = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // register file and counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            res_valid <= 1'b0;
            cmd_cnt   <= '0;
            err_cnt   <= '0;
            regs      <= '{default: '0};
        end else begin
            res_valid <= cmd_valid;
            if (cmd_valid) begin
                cmd_cnt <= cmd_cnt + 1'b1;
                if (!cmd_ok) begin
                    err_cnt <= err_cnt + 1'b1;
                end
                if (do_store) begin
                    regs[cmd_addr] <= new_val;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            res_status <= cmd_status;
            res_addr   <= cmd_addr;
            res_data   <= new_val;    // new value for WRITE and ADD
        end
    end

endmodule

/* hdl/resp_result.sv */
module resp_result (
    input  logic                                   clk,
    input  logic                                   nrst,
    input  logic                                   res_valid,
    input  logic [7:0]                             res_status,
    input  logic [spi_cmd_pkg::REG_ADDR_BITS-1:0]  res_addr,
    input  logic [spi_cmd_pkg::DATA_BITS-1:0]      res_data,
    output logic [spi_cmd_pkg::RESP_BITS-1:0]      resp_word
);
    import spi_cmd_pkg::*;

    logic [7:0]            addr_byte;
    logic [RESP_BITS-1:0]  next_word;

    // address goes out as a full byte
    assign addr_byte = {{(8 - REG_ADDR_BITS){1'b0}}, res_addr};

    // status first on the wire, then address, then data MSB first
    assign next_word = {res_status, addr_byte, res_data};

    ////////////////////////////////////////////////////////////
    // response holding register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            resp_word <= '0;
        end else if (res_valid) begin
            resp_word <= next_word;    // dropped frames leave this alone
        end
    end

endmodule

/* hdl/spi_cmd_pkg.sv */
package spi_cmd_pkg;

    ////////////////////////////////////////////////////////////
    // frame capture and response
    ////////////////////////////////////////////////////////////
    localparam int FRAME_BITS  = 440;              // 55 bytes of MOSI history
    localparam int FRAME_BYTES = FRAME_BITS / 8;
    localparam int LEN_BITS    = 11;               // byte count width
    localparam int RESP_BITS   = 48;               // status, addr, 4 data bytes

    ////////////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////////////
    localparam int REG_COUNT     = 16;
    localparam int REG_ADDR_BITS = 4;
    localparam int DATA_BITS     = 32;
    localparam int CNT_BITS      = 16;             // command and error counters

    // opcodes
    localparam logic [7:0] OP_WRITE  = 8'h01;
    localparam logic [7:0] OP_READ   = 8'h02;
    localparam logic [7:0] OP_ADD    = 8'h03;
    localparam logic [7:0] OP_STATUS = 8'h0F;

    // frame length of each opcode, in bytes
    localparam logic [LEN_BITS-1:0] LEN_WRITE  = 11'd6;
    localparam logic [LEN_BITS-1:0] LEN_READ   = 11'd2;
    localparam logic [LEN_BITS-1:0] LEN_ADD    = 11'd6;
    localparam logic [LEN_BITS-1:0] LEN_STATUS = 11'd1;

    // status codes
    localparam logic [7:0] ST_OK       = 8'h00;
    localparam logic [7:0] ST_BAD_LEN  = 8'hE1;
    localparam logic [7:0] ST_BAD_OP   = 8'hE2;
    localparam logic [7:0] ST_BAD_ADDR = 8'hE3;

endpackage

/* hdl/spi_cmd_top.sv */
module spi_cmd_top (
    input  logic clk,
    input  logic nrst,
    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso
);
    import spi_cmd_pkg::*;

    logic [FRAME_BITS-1:0]     frame_data;
    logic [LEN_BITS-1:0]       frame_len;
    logic                      frame_valid;

    logic                      cmd_valid;
    logic [7:0]                cmd_op;
    logic [REG_ADDR_BITS-1:0]  cmd_addr;
    logic [DATA_BITS-1:0]      cmd_data;
    logic [7:0]                cmd_status;

    logic                      res_valid;
    logic [7:0]                res_status;
    logic [REG_ADDR_BITS-1:0]  res_addr;
    logic [DATA_BITS-1:0]      res_data;

    logic [RESP_BITS-1:0]      resp_word;

    ////////////////////////////////////////////////////////////
    // frame port -> decode -> execute -> result -> frame port
    ////////////////////////////////////////////////////////////
    spi_frame_port u_frame_port (
        .clk         (clk),
        .nrst        (nrst),
        .spi_clk     (spi_clk),
        .spi_ss      (spi_ss),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .resp_word   (resp_word),
        .frame_data  (frame_data),
        .frame_len   (frame_len),
        .frame_valid (frame_valid)
    );

    cmd_decode u_decode (
        .clk         (clk),
        .nrst        (nrst),
        .frame_data  (frame_data),
        .frame_len   (frame_len),
        .frame_valid (frame_valid),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .cmd_status  (cmd_status)
    );

    reg_execute u_execute (
        .clk         (clk),
        .nrst        (nrst),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .cmd_status  (cmd_status),
        .res_valid   (res_valid),
        .res_status  (res_status),
        .res_addr    (res_addr),
        .res_data    (res_data)
    );

    resp_result u_result (
        .clk         (clk),
        .nrst        (nrst),
        .res_valid   (res_valid),
        .res_status  (res_status),
        .res_addr    (res_addr),
        .res_data    (res_data),
        .resp_word   (resp_word)
    );

endmodule

/* hdl/spi_frame_port.sv */
module spi_frame_port (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                spi_clk,
    input  logic                                spi_ss,
    input  logic                                spi_mosi,
    output logic                                spi_miso,
    input  logic [spi_cmd_pkg::RESP_BITS-1:0]   resp_word,
    output logic [spi_cmd_pkg::FRAME_BITS-1:0]  frame_data,
    output logic [spi_cmd_pkg::LEN_BITS-1:0]    frame_len,
    output logic                                frame_valid
);
    import spi_cmd_pkg::*;

    logic [1:0]              sck_sync;
    logic [1:0]              ss_sync;
    logic [1:0]              mosi_sync;
    logic                    sck_q;
    logic                    ss_q;
    logic                    sck_rise;
    logic                    sck_fall;
    logic                    ss_rise;
    logic                    ss_fall;
    logic [FRAME_BITS-1:0]   in_reg;
    logic [RESP_BITS-1:0]    out_reg;
    logic [LEN_BITS+2:0]     bit_cnt;      // bits of the current frame

    ////////////////////////////////////////////////////////////
    // synchronizers and edge detection
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sck_sync  <= '0;
            ss_sync   <= '1;               // idle deselected
            mosi_sync <= '0;
            sck_q     <= 1'b0;
            ss_q      <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], spi_clk};
            ss_sync   <= {ss_sync[0], spi_ss};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sck_q     <= sck_sync[1];
            ss_q      <= ss_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_q;
    assign sck_fall = ~sck_sync[1] & sck_q;
    assign ss_rise  = ss_sync[1] & ~ss_q;   // end of frame
    assign ss_fall  = ~ss_sync[1] & ss_q;   // start of frame

    // released as soon as the master deselects
    assign spi_miso = spi_ss ? 1'bz : out_reg[RESP_BITS-1];

    ////////////////////////////////////////////////////////////
    // MOSI capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (ss_fall) begin
            in_reg <= '0;
        end else if (sck_rise && !ss_sync[1]) begin
            in_reg <= {in_reg[FRAME_BITS-2:0], mosi_sync[1]};  // oldest bits fall off the top
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bit_cnt <= '0;
        end else if (ss_fall) begin
            bit_cnt <= '0;
        end else if (sck_rise && !ss_sync[1]) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // MISO shift register, MSB first on falling SCK
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            out_reg <= '0;
        end else if (ss_fall) begin
            out_reg <= resp_word;
        end else if (ss_rise) begin
            out_reg <= '0;
        end else if (sck_fall && !ss_sync[1]) begin
            out_reg <= {out_reg[RESP_BITS-2:0], 1'b0};
        end
    end

    ////////////////////////////////////////////////////////////
    // publish the frame on deselect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            frame_valid <= 1'b0;
            frame_len   <= '0;
        end else begin
            frame_valid <= ss_rise && (bit_cnt[2:0] == 3'd0);  // whole bytes only
            if (ss_rise) begin
                frame_len <= bit_cnt[LEN_BITS+2:3];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ss_rise) begin
            frame_data <= in_reg;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the SPI command slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_spi_cmd -f all.f \
    -Mdir obj_dir -o tb_spi_cmd > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/tb_spi_cmd > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q -F "** FAIL **" sim.log; then
    echo "test failed, see sim.log"
    exit 1
fi
if ! grep -q -F "** PASS **" sim.log; then
    echo "no result found in sim.log"
    exit 1
fi

echo "test passed"
exit 0

/* verification/clk_gen.sv */
module clk_gen (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // period of 8
    end

    // reset held for the first 10 rising edges
    initial begin
        nrst = 1'b0;
        repeat (10) @(posedge clk);
        nrst <= 1'b1;
    end

endmodule

/* verification/spi_cmd_checker.sv */
module spi_cmd_checker (
    input  logic clk,
    input  logic nrst,
    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    input  logic spi_miso,
    input  logic miso_released,
    output int   error_count,
    output int   frame_count
);
    import spi_cmd_pkg::*;

    logic [DATA_BITS-1:0]  model_regs [REG_COUNT];
    logic [CNT_BITS-1:0]   model_cmds;
    logic [CNT_BITS-1:0]   model_errs;
    logic [RESP_BITS-1:0]  exp_resp;      // what the next frame should shift out
    logic [63:0]           mosi_bits;
    logic [63:0]           miso_bits;
    int                    nbits;
    logic                  ss_q;
    logic                  sck_q;

    // byte k of a frame, k = 0 is the first byte on the wire
    function automatic logic [7:0] frame_byte(input logic [63:0] bits, input int nbytes,
                                              input int k);
        return 8'(bits >> (8 * (nbytes - 1 - k)));
    endfunction

    task automatic check_miso;
        logic [63:0] expected;
        if (nbits <= RESP_BITS) begin
            expected = 64'(exp_resp) >> (RESP_BITS - nbits);
        end else begin
            expected = 64'(exp_resp) << (nbits - RESP_BITS);   // zeros after the word
        end
        if (miso_bits !== expected) begin
            error_count++;
            $display("[ERROR] resp_word frame %0d expected %h actual %h",
                     frame_count, expected, miso_bits);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model of one whole-byte command
    ////////////////////////////////////////////////////////////
    task automatic run_model;
        int                        nbytes;
        int                        want_len;
        logic                      needs_addr;
        logic [7:0]                op;
        logic [7:0]                addr_b;
        logic [7:0]                status;
        logic [REG_ADDR_BITS-1:0]  idx;
        logic [DATA_BITS-1:0]      operand;
        logic [DATA_BITS-1:0]      result;
        nbytes     = nbits / 8;
        op         = (nbytes > 0) ? frame_byte(mosi_bits, nbytes, 0) : 8'h00;
        addr_b     = (nbytes > 1) ? frame_byte(mosi_bits, nbytes, 1) : 8'h00;
        operand    = '0;
        result     = '0;
        idx        = '0;
        needs_addr = 1'b1;
        want_len   = 0;
        if (nbytes >= 6) begin
            operand = {frame_byte(mosi_bits, nbytes, 2), frame_byte(mosi_bits, nbytes, 3),
                       frame_byte(mosi_bits, nbytes, 4), frame_byte(mosi_bits, nbytes, 5)};
        end
        case (op)
            OP_WRITE, OP_ADD: want_len = 6;
            OP_READ:          want_len = 2;
            OP_STATUS: begin
                want_len   = 1;
                needs_addr = 1'b0;
            end
            default: needs_addr = 1'b0;
        endcase

        if (want_len == 0) begin
            status = ST_BAD_OP;
        end else if (nbytes != want_len) begin
            status = ST_BAD_LEN;
        end else if (needs_addr && addr_b >= 8'(REG_COUNT)) begin
            status = ST_BAD_ADDR;
        end else begin
            status = ST_OK;
            if (needs_addr) idx = addr_b[REG_ADDR_BITS-1:0];
            case (op)
                OP_WRITE: model_regs[idx] = operand;
                OP_ADD:   model_regs[idx] = model_regs[idx] + operand;
                default:  ;
            endcase
            result = (op == OP_STATUS) ? {model_cmds, model_errs} : model_regs[idx];
        end

        model_cmds = model_cmds + 1'b1;
        if (status != ST_OK) model_errs = model_errs + 1'b1;
        exp_resp = {status, 8'(idx), result};
    endtask

    initial begin
        error_count = 0;
        frame_count = 0;
        model_cmds  = '0;
        model_errs  = '0;
        exp_resp    = '0;
        mosi_bits   = '0;
        miso_bits   = '0;
        nbits       = 0;
        ss_q        = 1'b1;
        sck_q       = 1'b0;
        for (int r = 0; r < REG_COUNT; r++) model_regs[r] = '0;
    end

    ////////////////////////////////////////////////////////////
    // pin monitor
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (nrst) begin
            if (spi_ss && !miso_released) begin
                error_count++;
                $display("[ERROR] spi_miso expected z actual %h", spi_miso);
            end
            if (!spi_ss && miso_released) begin
                error_count++;
                $display("[ERROR] spi_miso expected driven actual %h", spi_miso);
            end

            if (!spi_ss && ss_q) begin        // frame start
                nbits     = 0;
                mosi_bits = '0;
                miso_bits = '0;
            end else if (!spi_ss && spi_clk && !sck_q) begin
                mosi_bits = {mosi_bits[62:0], spi_mosi};
                miso_bits = {miso_bits[62:0], spi_miso};
                nbits++;
            end

            if (spi_ss && !ss_q) begin        // frame end
                check_miso();
                if (nbits % 8 == 0) run_model();   // partial bytes change nothing
                frame_count++;
            end
            ss_q  = spi_ss;
            sck_q = spi_clk;
        end
    end

endmodule

/* verification/tb_spi_cmd.sv */
module tb_spi_cmd;
    import spi_cmd_pkg::*;

    localparam int SCK_HALF      = 4;     // clk cycles per SCK half period
    localparam int FRAME_GAP     = 20;
    localparam int NUM_FRAMES    = 200;
    localparam int RESET_TIMEOUT = 100;
    localparam int SEEN_TIMEOUT  = 50;

    logic        clk;
    logic        nrst;
    logic        spi_clk;
    logic        spi_ss;
    logic        spi_mosi;
    wire         spi_miso;
    wire         miso_released;
    int          seed;
    int          sent;
    int          stim_errors;
    int          checker_errors;
    int          frames_seen;
    int          wait_t;
    int          nbits;
    logic [63:0] raw;

    assign miso_released = (spi_miso === 1'bz);

    clk_gen u_clk_gen (.clk(clk), .nrst(nrst));

    spi_cmd_top i_dut (
        .clk      (clk),
        .nrst     (nrst),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    spi_cmd_checker u_checker (
        .clk           (clk),
        .nrst          (nrst),
        .spi_clk       (spi_clk),
        .spi_ss        (spi_ss),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso),
        .miso_released (miso_released),
        .error_count   (checker_errors),
        .frame_count   (frames_seen)
    );

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // SPI master, first bit on the wire is bits[63]
    ////////////////////////////////////////////////////////////
    task automatic send_frame(input logic [63:0] bits, input int len);
        logic [63:0] sh;
        sh = bits;
        @(posedge clk);
        spi_ss   <= 1'b0;
        spi_mosi <= sh[63];
        idle(SCK_HALF);
        for (int k = 0; k < len; k++) begin
            spi_clk <= 1'b1;
            idle(SCK_HALF);
            sh = sh << 1;
            spi_clk  <= 1'b0;
            spi_mosi <= sh[63];
            idle(SCK_HALF);
        end
        spi_ss <= 1'b1;
        sent++;
    endtask

    task automatic wait_checker;
        int t;
        t = 0;
        while (frames_seen != sent && t < SEEN_TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (frames_seen != sent) begin
            $display("timeout: checker never saw the end of frame %0d", sent);
            stim_errors++;
        end
    endtask

    task automatic make_frame(output logic [63:0] bits, output int len);
        logic [31:0] pick;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [7:0]  op;
        logic [7:0]  addr;
        int          proper;
        pick = $random(seed);
        r1   = $random(seed);
        r2   = $random(seed);
        r3   = $random(seed);
        pick = pick % 100;
        case (r1[1:0])
            2'd0:    op = OP_WRITE;
            2'd1:    op = OP_READ;
            2'd2:    op = OP_ADD;
            default: op = OP_STATUS;
        endcase
        if (pick >= 78 && pick < 88 && op == OP_STATUS) op = OP_ADD;   // needs an address
        if (pick >= 60 && pick < 68) begin
            op = r1[23:16];
            if (op == OP_WRITE || op == OP_READ || op == OP_ADD || op == OP_STATUS) begin
                op = op ^ 8'h80;
            end
        end
        proper = (op == OP_STATUS) ? 1 : (op == OP_READ) ? 2 : 6;
        // wrong lengths sometimes carry a bad address too, length must win
        addr   = ((pick >= 78 && pick < 88) || (pick >= 68 && pick < 78 && r1[31]))
               ? 8'(16 + r1[15:8] % 240) : {4'h0, r1[11:8]};

        if (pick < 60) begin
            len = proper * 8;
        end else if (pick < 68) begin
            len = 8 * (1 + r3 % 8);
        end else if (pick < 78) begin
            len = 1 + r3 % 8;
            if (len == proper) len = proper + 1;
            len = len * 8;
        end else if (pick < 88) begin
            len = proper * 8;
        end else begin
            len = 1 + r3 % 63;                 // odd bit count
            if (len % 8 == 0) len = len + 1;
        end
        bits = {op, addr, r2, r3[15:0]};
    endtask

    initial begin
        seed        = 88219;
        sent        = 0;
        stim_errors = 0;
        spi_clk     = 1'b0;
        spi_ss      = 1'b1;
        spi_mosi    = 1'b0;

        for (wait_t = 0; wait_t < RESET_TIMEOUT && nrst !== 1'b1; wait_t++) @(posedge clk);
        if (nrst !== 1'b1) begin
            $display("timeout: reset was never released");
            stim_errors++;
        end
        idle(FRAME_GAP);

        for (int i = 0; i < NUM_FRAMES && stim_errors == 0; i++) begin
            make_frame(raw, nbits);
            send_frame(raw, nbits);
            wait_checker();
            idle(FRAME_GAP);
        end

        // final status, then a filler frame to read its response out
        if (stim_errors == 0) begin
            send_frame({OP_STATUS, 56'h0}, 8);
            wait_checker();
            idle(FRAME_GAP);
            send_frame(64'h0, RESP_BITS);
            wait_checker();
            idle(FRAME_GAP);
        end
        if (frames_seen != sent) begin
            $display("checker counted %0d frames but %0d were sent", frames_seen, sent);
            stim_errors++;
        end

        $display("errors: %0d (checker %0d, stimulus %0d) over %0d frames",
                 checker_errors + stim_errors, checker_errors, stim_errors, sent);
        if (checker_errors == 0 && stim_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
